// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard rtl/*.sv verif/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
rtl/dcache_pkg.sv
rtl/cache_ways.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/mem_model.sv
verif/dcache_props.sv
verif/tb_dcache.sv

// ==== rtl/cache_ways.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_ways import dcache_pkg::*; #(
    parameter int INDEX_BITS = DEF_INDEX_BITS
) (
    input  logic                                        CLK,
    input  logic                                        n_rst,
    input  word_t                                       dmemaddr,
    input  logic                                        dmemREN,
    input  logic                                        dmemWEN,
    input  word_t                                       dmemstore,
    input  logic                                        lookup_en,
    output logic                                        hit,
    output word_t                                       hit_word,
    output way_t                                        victim_way,
    output logic                                        victim_dirty,
    output logic [31-INDEX_BITS-1-BYTE_OFF_BITS:0]      victim_tag,
    input  logic [INDEX_BITS-1:0]                       line_idx,
    input  way_t                                        line_way,
    input  logic                                        line_sel,
    input  line_op_t                                    line_op,
    input  word_t                                       fill_data,
    output logic [31-INDEX_BITS-1-BYTE_OFF_BITS:0]      line_tag,
    output logic                                        line_dirty,
    output word_t                                       line_word
);
    localparam int SETS     = 1 << INDEX_BITS;
    localparam int BLK_BITS = $clog2(WORDS_PER_BLOCK);
    localparam int TAG_BITS = 32 - INDEX_BITS - BLK_BITS - BYTE_OFF_BITS;

    logic [TAG_BITS-1:0] tag_mem [2][SETS];
    word_t               data_mem [2][SETS][WORDS_PER_BLOCK];
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      lru_q;  // names the way to evict next

    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] req_idx;
    logic [BLK_BITS-1:0]   req_blk;
    logic [1:0]            way_hit;
    way_t                  hit_way;

    assign req_tag = dmemaddr[31 -: TAG_BITS];
    assign req_idx = dmemaddr[BYTE_OFF_BITS+BLK_BITS +: INDEX_BITS];
    assign req_blk = dmemaddr[BYTE_OFF_BITS +: BLK_BITS];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][req_idx] && (tag_mem[w][req_idx] == req_tag);
        end
    end

    assign hit_way  = way_hit[1];
    assign hit      = lookup_en && (dmemREN || dmemWEN) && (|way_hit);
    assign hit_word = data_mem[hit_way][req_idx][req_blk];

    assign victim_way   = lru_q[req_idx];
    assign victim_dirty = valid_q[victim_way][req_idx] && dirty_q[victim_way][req_idx];
    assign victim_tag   = tag_mem[victim_way][req_idx];

    // line selected by the controller, read side
    assign line_tag   = tag_mem[line_way][line_idx];
    assign line_dirty = valid_q[line_way][line_idx] && dirty_q[line_way][line_idx];
    assign line_word  = data_mem[line_way][line_idx][line_sel];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (hit) begin
                lru_q[req_idx] <= ~hit_way;  // other way goes next
                if (dmemWEN) begin
                    dirty_q[hit_way][req_idx] <= 1'b1;
                end
            end
            case (line_op)
                LINE_VALIDATE: begin
                    valid_q[line_way][line_idx] <= 1'b1;
                    dirty_q[line_way][line_idx] <= 1'b0;
                end
                LINE_CLEAN: begin
                    dirty_q[line_way][line_idx] <= 1'b0;
                end
                LINE_INVALIDATE_ALL: begin
                    valid_q <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (hit && dmemWEN) begin
            data_mem[hit_way][req_idx][req_blk] <= dmemstore;
        end
        if (line_op == LINE_FILL_WORD) begin
            data_mem[line_way][line_idx][line_sel] <= fill_data;
            tag_mem[line_way][line_idx]            <= req_tag;  // request held during fill
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int INDEX_BITS = DEF_INDEX_BITS
) (
    input  logic                                        CLK,
    input  logic                                        n_rst,
    input  logic                                        halt,
    input  word_t                                       dmemaddr,
    input  logic                                        dmemREN,
    input  logic                                        dmemWEN,
    input  logic                                        hit,
    input  way_t                                        victim_way,
    input  logic                                        victim_dirty,
    input  logic [31-INDEX_BITS-1-BYTE_OFF_BITS:0]      victim_tag,
    input  logic [31-INDEX_BITS-1-BYTE_OFF_BITS:0]      line_tag,
    input  logic                                        line_dirty,
    input  word_t                                       line_word,
    output logic                                        lookup_en,
    output logic [INDEX_BITS-1:0]                       line_idx,
    output way_t                                        line_way,
    output logic                                        line_sel,
    output line_op_t                                    line_op,
    output logic                                        dREN,
    output logic                                        dWEN,
    output word_t                                       daddr,
    output word_t                                       dstore,
    input  logic                                        dwait,
    output logic                                        flushed
);
    localparam int BLK_BITS = $clog2(WORDS_PER_BLOCK);
    localparam int BLK_LSB  = BYTE_OFF_BITS + BLK_BITS;
    localparam logic [INDEX_BITS-1:0] LAST_IDX = '1;

    ctrl_state_t           state, next_state;
    logic [INDEX_BITS-1:0] idx_q, next_idx;
    way_t                  way_q, next_way;
    logic                  replay, next_replay;
    word_t                 hit_count, next_hit_count;
    logic                  next_dREN, next_dWEN;
    word_t                 next_daddr, next_dstore;

    logic [INDEX_BITS-1:0] req_idx;
    word_t                 fill_addr0;
    word_t                 fill_addr1;
    logic                  req;

    assign req        = dmemREN | dmemWEN;
    assign req_idx    = dmemaddr[BLK_LSB +: INDEX_BITS];
    assign fill_addr0 = {dmemaddr[31:BLK_LSB], BLK_BITS'(0), {BYTE_OFF_BITS{1'b0}}};
    assign fill_addr1 = {dmemaddr[31:BLK_LSB], BLK_BITS'(1), {BYTE_OFF_BITS{1'b0}}};

    assign lookup_en = (state == ST_IDLE) && !halt;  // halt wins over a request
    assign flushed   = (state == ST_FLUSHED);

    // in idle the line is the victim of the current request
    assign line_idx = (state == ST_IDLE) ? req_idx : idx_q;
    assign line_way = (state == ST_IDLE) ? victim_way : way_q;
    assign line_sel = (state == ST_WB_WORD0) || (state == ST_FILL_WORD1) ||
                      (state == ST_FLUSH_WORD0);

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= ST_IDLE;
            idx_q     <= '0;
            way_q     <= '0;
            replay    <= 1'b0;
            hit_count <= '0;
            dREN      <= 1'b0;
            dWEN      <= 1'b0;
        end else begin
            state     <= next_state;
            idx_q     <= next_idx;
            way_q     <= next_way;
            replay    <= next_replay;
            hit_count <= next_hit_count;
            dREN      <= next_dREN;
            dWEN      <= next_dWEN;
        end
    end

    always_ff @(posedge CLK) begin
        daddr  <= next_daddr;
        dstore <= next_dstore;
    end

    always_comb begin
        next_state     = state;
        next_idx       = idx_q;
        next_way       = way_q;
        next_replay    = replay;
        next_hit_count = hit_count;
        next_dREN      = dREN;  // bus request held until dwait drops
        next_dWEN      = dWEN;
        next_daddr     = daddr;
        next_dstore    = dstore;
        line_op        = LINE_NONE;

        case (state)
            ST_IDLE: begin
                if (halt) begin
                    next_state = ST_FLUSH_SCAN;
                    next_idx   = '0;
                    next_way   = 1'b0;
                end else if (hit) begin
                    if (replay) begin
                        next_replay = 1'b0;
                    end else begin
                        next_hit_count = hit_count + 32'd1;
                    end
                end else if (req) begin
                    next_idx = req_idx;
                    next_way = victim_way;
                    if (victim_dirty) begin
                        next_state  = ST_WB_WORD0;
                        next_dWEN   = 1'b1;
                        next_daddr  = {victim_tag, req_idx, BLK_BITS'(0), {BYTE_OFF_BITS{1'b0}}};
                        next_dstore = line_word;
                    end else begin
                        next_state = ST_FILL_WORD0;
                        next_dREN  = 1'b1;
                        next_daddr = fill_addr0;
                        line_op    = LINE_VALIDATE;  // hidden while lookup is off
                    end
                end
            end
            ST_WB_WORD0: begin
                if (!dwait) begin
                    next_state  = ST_WB_WORD1;
                    next_daddr  = {line_tag, idx_q, BLK_BITS'(1), {BYTE_OFF_BITS{1'b0}}};
                    next_dstore = line_word;
                end
            end
            ST_WB_WORD1: begin
                if (!dwait) begin
                    next_state = ST_FILL_WORD0;
                    next_dWEN  = 1'b0;
                    next_dREN  = 1'b1;
                    next_daddr = fill_addr0;
                    line_op    = LINE_VALIDATE;
                end
            end
            ST_FILL_WORD0: begin
                if (!dwait) begin
                    next_state = ST_FILL_WORD1;
                    next_daddr = fill_addr1;
                    line_op    = LINE_FILL_WORD;
                end
            end
            ST_FILL_WORD1: begin
                if (!dwait) begin
                    next_state  = ST_IDLE;
                    next_dREN   = 1'b0;
                    next_replay = 1'b1;  // next hit is the replay, not counted
                    line_op     = LINE_FILL_WORD;
                end
            end
            ST_FLUSH_SCAN: begin
                if (line_dirty) begin
                    next_state  = ST_FLUSH_WORD0;
                    next_dWEN   = 1'b1;
                    next_daddr  = {line_tag, idx_q, BLK_BITS'(0), {BYTE_OFF_BITS{1'b0}}};
                    next_dstore = line_word;
                end else if (idx_q == LAST_IDX && way_q == 1'b1) begin
                    next_state  = ST_COUNT_WRITE;
                    next_dWEN   = 1'b1;
                    next_daddr  = COUNTER_ADDR;
                    next_dstore = hit_count;
                end else begin
                    {next_idx, next_way} = {idx_q, way_q} + 1'b1;  // way 0 then way 1
                end
            end
            ST_FLUSH_WORD0: begin
                if (!dwait) begin
                    next_state  = ST_FLUSH_WORD1;
                    next_daddr  = {line_tag, idx_q, BLK_BITS'(1), {BYTE_OFF_BITS{1'b0}}};
                    next_dstore = line_word;
                end
            end
            ST_FLUSH_WORD1: begin
                if (!dwait) begin
                    // rescan sees the line clean and moves on
                    next_state = ST_FLUSH_SCAN;
                    next_dWEN  = 1'b0;
                    line_op    = LINE_CLEAN;
                end
            end
            ST_COUNT_WRITE: begin
                if (!dwait) begin
                    next_state = ST_FLUSHED;
                    next_dWEN  = 1'b0;
                    line_op    = LINE_INVALIDATE_ALL;
                end
            end
            ST_FLUSHED: begin
                next_state = ST_FLUSHED;  // held until reset
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic        way_t;

    // block geometry is fixed, only the set count scales
    localparam int WORDS_PER_BLOCK = 2;
    localparam int BYTE_OFF_BITS   = 2;
    localparam int DEF_INDEX_BITS  = 3;

    localparam word_t COUNTER_ADDR = 32'h3100;  // hit count lands here on flush

    typedef enum logic [2:0] {
        LINE_NONE,
        LINE_FILL_WORD,
        LINE_VALIDATE,
        LINE_CLEAN,
        LINE_INVALIDATE_ALL
    } line_op_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WB_WORD0,
        ST_WB_WORD1,
        ST_FILL_WORD0,
        ST_FILL_WORD1,
        ST_FLUSH_SCAN,
        ST_FLUSH_WORD0,
        ST_FLUSH_WORD1,
        ST_COUNT_WRITE,
        ST_FLUSHED
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_BITS = DEF_INDEX_BITS
) (
    input  logic  CLK,
    input  logic  n_rst,
    input  logic  halt,
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output logic  dhit,
    output word_t dmemload,
    output logic  flushed,
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);
    localparam int TAG_BITS = 32 - INDEX_BITS - 1 - BYTE_OFF_BITS;

    logic                  lookup_en;
    logic                  hit;
    word_t                 hit_word;
    way_t                  victim_way;
    logic                  victim_dirty;
    logic [TAG_BITS-1:0]   victim_tag;
    logic [INDEX_BITS-1:0] line_idx;
    way_t                  line_way;
    logic                  line_sel;
    line_op_t              line_op;
    logic [TAG_BITS-1:0]   line_tag;
    logic                  line_dirty;
    word_t                 line_word;

    assign dhit     = hit;
    assign dmemload = hit_word;

    cache_ways #(.INDEX_BITS(INDEX_BITS)) u_ways (
        .CLK          (CLK),
        .n_rst        (n_rst),
        .dmemaddr     (dmemaddr),
        .dmemREN      (dmemREN),
        .dmemWEN      (dmemWEN),
        .dmemstore    (dmemstore),
        .lookup_en    (lookup_en),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_idx     (line_idx),
        .line_way     (line_way),
        .line_sel     (line_sel),
        .line_op      (line_op),
        .fill_data    (dload),
        .line_tag     (line_tag),
        .line_dirty   (line_dirty),
        .line_word    (line_word)
    );

    dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
        .CLK          (CLK),
        .n_rst        (n_rst),
        .halt         (halt),
        .dmemaddr     (dmemaddr),
        .dmemREN      (dmemREN),
        .dmemWEN      (dmemWEN),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_tag     (line_tag),
        .line_dirty   (line_dirty),
        .line_word    (line_word),
        .lookup_en    (lookup_en),
        .line_idx     (line_idx),
        .line_way     (line_way),
        .line_sel     (line_sel),
        .line_op      (line_op),
        .dREN         (dREN),
        .dWEN         (dWEN),
        .daddr        (daddr),
        .dstore       (dstore),
        .dwait        (dwait),
        .flushed      (flushed)
    );

endmodule

`default_nettype wire

// ==== verif/dcache_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_props import dcache_pkg::*; (
    input logic  CLK,
    input logic  n_rst,
    input logic  dmemREN,
    input logic  dmemWEN,
    input logic  dhit,
    input logic  flushed,
    input logic  dREN,
    input logic  dWEN,
    input word_t daddr,
    input word_t dstore,
    input logic  dwait
);
    logic tripped;
    logic both_seen  = 1'b0;
    logic moved_seen = 1'b0;
    logic fell_seen  = 1'b0;
    logic stray_seen = 1'b0;

    assign tripped = both_seen | moved_seen | fell_seen | stray_seen;

    a_one_dir: assert property (@(posedge CLK) disable iff (!n_rst) !(dREN && dWEN))
    else begin
        both_seen = 1'b1;
        $error("dREN and dWEN high in the same cycle");
    end

    // stalled bus request must not move
    a_req_held: assert property (@(posedge CLK) disable iff (!n_rst)
        (dREN || dWEN) && dwait |=> $stable(dREN) && $stable(dWEN) &&
                                    $stable(daddr) && $stable(dstore))
    else begin
        moved_seen = 1'b1;
        $error("bus request changed while dwait was high");
    end

    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!n_rst) flushed |=> flushed)
    else begin
        fell_seen = 1'b1;
        $error("flushed fell after rising");
    end

    // a hit answers a datapath request with the bus idle
    a_hit_needs_req: assert property (@(posedge CLK) disable iff (!n_rst)
        dhit |-> (dmemREN || dmemWEN) && !dREN && !dWEN)
    else begin
        stray_seen = 1'b1;
        $error("dhit without a datapath request or with a bus request pending");
    end

endmodule

bind dcache_top dcache_props u_props (
    .CLK     (CLK),
    .n_rst   (n_rst),
    .dmemREN (dmemREN),
    .dmemWEN (dmemWEN),
    .dhit    (dhit),
    .flushed (flushed),
    .dREN    (dREN),
    .dWEN    (dWEN),
    .daddr   (daddr),
    .dstore  (dstore),
    .dwait   (dwait)
);

`default_nettype wire

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model import dcache_pkg::*; #(
    parameter int WORDS     = 4096,
    parameter int MAX_STALL = 3
) (
    input  logic        CLK,
    input  logic        n_rst,
    input  logic        dREN,
    input  logic        dWEN,
    input  word_t       daddr,
    input  word_t       dstore,
    output word_t       dload,
    output logic        dwait,
    output int unsigned write_count
);
    localparam int AW = $clog2(WORDS);

    word_t       mem [WORDS];
    int unsigned stall_run;

    // every word starts from a scramble of its full byte address
    function automatic word_t fill_value(word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = fill_value(word_t'(i) << 2);
        end
    end

    assign dload = dREN ? mem[daddr[AW+1:2]] : '0;  // valid in the completing cycle

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            dwait       <= 1'b1;
            stall_run   <= 0;
            write_count <= 0;
        end else begin
            if (stall_run >= MAX_STALL) begin
                dwait     <= 1'b0;  // stall runs are capped
                stall_run <= 0;
            end else if (($urandom % 3) == 0) begin
                dwait     <= 1'b1;
                stall_run <= stall_run + 1;
            end else begin
                dwait     <= 1'b0;
                stall_run <= 0;
            end
            if (dWEN && !dwait) begin
                write_count <= write_count + 1;
            end
        end
    end

    always @(posedge CLK) begin
        if (n_rst && dWEN && !dwait) begin
            mem[daddr[AW+1:2]] <= dstore;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int INDEX_BITS   = DEF_INDEX_BITS;
    localparam int SETS         = 1 << INDEX_BITS;
    localparam int BLK_LSB      = BYTE_OFF_BITS + 1;
    localparam int TAG_LSB      = BLK_LSB + INDEX_BITS;
    localparam int MEM_WORDS    = 4096;
    localparam int NUM_REQS     = 400;
    localparam int REQ_BOUND    = 40;   // cycles, dirty miss with capped stalls
    localparam int FLUSH_BOUND  = 400;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_REQS * REQ_BOUND + FLUSH_BOUND;

    logic        CLK = 1'b0;
    logic        n_rst;
    logic        halt;
    logic        dmemREN;
    logic        dmemWEN;
    word_t       dmemaddr;
    word_t       dmemstore;
    logic        dhit;
    word_t       dmemload;
    logic        flushed;
    logic        dREN;
    logic        dWEN;
    word_t       daddr;
    word_t       dstore;
    word_t       dload;
    logic        dwait;
    int unsigned write_count;

    // reference model state
    word_t       flat [MEM_WORDS];
    logic        m_valid [2][SETS];
    logic        m_dirty [2][SETS];
    word_t       m_tag [2][SETS];
    logic        m_lru [SETS];
    word_t       hit_total;
    int unsigned exp_writes;
    logic        exp_wr_q [$];
    word_t       exp_addr_q [$];
    word_t       exp_data_q [$];

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    dcache_top #(.INDEX_BITS(INDEX_BITS)) u_dut (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .halt      (halt),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait)
    );

    mem_model #(.WORDS(MEM_WORDS), .MAX_STALL(3)) u_mem (
        .CLK         (CLK),
        .n_rst       (n_rst),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .daddr       (daddr),
        .dstore      (dstore),
        .dload       (dload),
        .dwait       (dwait),
        .write_count (write_count)
    );

    function automatic word_t fill_value(word_t addr);  // same scramble as the memory
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic int set_of(word_t addr);
        return int'((addr >> BLK_LSB) % SETS);
    endfunction

    function automatic word_t block_base(word_t tag, int idx);
        return (tag << TAG_LSB) | (word_t'(idx) << BLK_LSB);
    endfunction

    // few tags per set so that sets conflict
    function automatic word_t pick_addr();
        word_t region;
        word_t idx;
        word_t sel;
        region = word_t'($urandom % 4);
        idx    = word_t'($urandom % SETS);
        sel    = word_t'($urandom % 2);
        return region * 32'h0C00 + (idx << BLK_LSB) + (sel << BYTE_OFF_BITS);
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: hit count is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic expect_xfer(input logic wr, input word_t addr, input word_t data);
        exp_wr_q.push_back(wr);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        if (wr) begin
            exp_writes += 1;
        end
    endtask

    // one completed bus word against the head of the expected list
    task automatic check_xfer();
        logic  wr;
        word_t addr;
        word_t data;
        if (exp_wr_q.size() == 0) begin
            $display("bus transfer at %h when none was expected (time %0t)", daddr, $time);
            abort_run();
        end else begin
            wr   = exp_wr_q.pop_front();
            addr = exp_addr_q.pop_front();
            data = exp_data_q.pop_front();
            check_flag("bus write enable", dWEN, wr);
            check_word("bus address", daddr, addr);
            if (wr) begin
                check_word("bus write data", dstore, data);
            end
        end
    endtask

    task automatic model_access(input logic write, input word_t addr, input word_t data,
                                output logic was_hit);
        int    idx;
        int    v;
        word_t tag;
        word_t vbase;
        word_t base;
        idx     = set_of(addr);
        tag     = addr >> TAG_LSB;
        base    = addr & ~word_t'(7);
        v       = int'(m_lru[idx]);
        was_hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                was_hit = 1'b1;
                v       = w;
            end
        end
        if (!was_hit) begin
            if (m_valid[v][idx] && m_dirty[v][idx]) begin
                vbase = block_base(m_tag[v][idx], idx);
                expect_xfer(1'b1, vbase, flat[int'(vbase >> 2)]);
                expect_xfer(1'b1, vbase + 4, flat[int'(vbase >> 2) + 1]);
            end
            expect_xfer(1'b0, base, '0);
            expect_xfer(1'b0, base + 4, '0);
            m_valid[v][idx] = 1'b1;
            m_tag[v][idx]   = tag;
            m_dirty[v][idx] = 1'b0;
        end
        m_lru[idx] = (v == 0);  // replay hit or real hit
        if (write) begin
            m_dirty[v][idx]       = 1'b1;
            flat[int'(addr >> 2)] = data;
        end
    endtask

    task automatic do_access(input logic write, input word_t addr, input word_t data);
        word_t exp_load;
        logic  predicted_hit;
        exp_load = flat[int'(addr >> 2)];
        model_access(write, addr, data, predicted_hit);
        if (predicted_hit) begin
            hit_total += 1;
        end
        @(posedge CLK);
        dmemREN   <= !write;
        dmemWEN   <= write;
        dmemaddr  <= addr;
        dmemstore <= data;
        @(negedge CLK);
        check_flag("dhit on first cycle", dhit, predicted_hit);
        if (predicted_hit) begin
            check_flag("dREN on a hit", dREN, 1'b0);
            check_flag("dWEN on a hit", dWEN, 1'b0);
        end
        while (!dhit) begin
            if ((dREN || dWEN) && !dwait) begin
                check_xfer();
            end
            @(negedge CLK);
        end
        if (exp_wr_q.size() != 0) begin
            $display("dhit at %0t with %0d bus words still missing", $time, exp_wr_q.size());
            abort_run();
        end
        if (!write) begin
            check_word("load data", dmemload, exp_load);
        end
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            dmemREN <= 1'b0;
            dmemWEN <= 1'b0;
        end
    endtask

    task automatic run_flush();
        word_t base;
        for (int i = 0; i < SETS; i++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[w][i] && m_dirty[w][i]) begin
                    base = block_base(m_tag[w][i], i);
                    expect_xfer(1'b1, base, flat[int'(base >> 2)]);
                    expect_xfer(1'b1, base + 4, flat[int'(base >> 2) + 1]);
                end
            end
        end
        expect_xfer(1'b1, COUNTER_ADDR, hit_total);
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        halt    <= 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            if ((dREN || dWEN) && !dwait) begin
                check_xfer();
            end
            @(negedge CLK);
        end
        if (exp_wr_q.size() != 0) begin
            $display("flushed rose with %0d bus words still missing", exp_wr_q.size());
            abort_run();
        end
        repeat (10) begin  // quiet bus and sticky flag afterwards
            @(negedge CLK);
            check_flag("flushed after flush", flushed, 1'b1);
            check_flag("dREN after flush", dREN, 1'b0);
            check_flag("dWEN after flush", dWEN, 1'b0);
        end
    endtask

    always @(negedge CLK) begin
        if (u_dut.u_props.tripped) begin
            $display("a bus protocol assertion on the DUT failed");
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin
        logic  write;
        logic  last_store;
        word_t addr;
        word_t last_addr;
        word_t data;
        void'($urandom(32'h6fc1));
        n_rst      = 1'b0;
        halt       = 1'b0;
        dmemREN    = 1'b0;
        dmemWEN    = 1'b0;
        dmemaddr   = '0;
        dmemstore  = '0;
        hit_total  = '0;
        exp_writes = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            flat[i] = fill_value(word_t'(i) << 2);
        end
        for (int i = 0; i < SETS; i++) begin
            m_lru[i] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[w][i] = 1'b0;
                m_dirty[w][i] = 1'b0;
                m_tag[w][i]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        n_rst <= 1'b1;
        @(negedge CLK);
        check_flag("flushed after reset", flushed, 1'b0);
        check_flag("dREN after reset", dREN, 1'b0);
        check_flag("dWEN after reset", dWEN, 1'b0);

        last_store = 1'b0;
        last_addr  = '0;
        for (int n = 0; n < NUM_REQS; n++) begin
            if (last_store && ($urandom % 3) == 0) begin
                write = 1'b0;  // read back the word just stored
                addr  = last_addr;
            end else begin
                write = (($urandom % 2) == 1);
                addr  = pick_addr();
            end
            data = $urandom;
            do_access(write, addr, data);
            last_store = write;
            last_addr  = addr;
            idle_gap(int'($urandom % 3));
        end

        run_flush();
        for (int i = 0; i < 32'h3000 / 4; i++) begin
            check_word("memory image word", u_mem.mem[i], flat[i]);
        end
        check_count(u_mem.mem[int'(COUNTER_ADDR >> 2)], hit_total);
        check_word("memory write count", word_t'(write_count), word_t'(exp_writes));
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
